//--- tb.f
src/core_pkg.sv
src/isa_pkg.sv
src/decoder.sv
src/scalar_reg_file.sv
src/vector_reg_file.sv
src/vector_alu.sv
src/mem_port.sv
src/core_control.sv
src/vector_core.sv
sim/vector_core_chk.sv
sim/tb_vector_core.sv

//--- sim/tb_vector_core.sv
// vector core testbench
// runs a scalar and vector program through the core, serves both
// four-phase ports with random ack delays and checks every store
// against a software model of the same program
`timescale 1ns/1ns

module tb_vector_core
    import core_pkg::*;
();

    logic  clk;
    logic  rst;
    logic  imem_req;
    addr_t imem_addr;
    word_t imem_rdata;
    logic  imem_ack;
    logic  dmem_req;
    addr_t dmem_addr;
    vreg_t dmem_wdata;
    strb_t dmem_strb;
    logic  dmem_ack;

    integer seed;
    word_t  prog [$];
    int     exp_pc [$];
    addr_t  exp_addr [$];
    strb_t  exp_strb [$];
    vreg_t  exp_data [$];
    addr_t  got_addr [$];
    strb_t  got_strb [$];
    vreg_t  got_data [$];
    int     n_checks;
    int     n_errors;
    int     stores_seen;
    int     cycle_limit;

    vector_core i_dut (
        .clk(clk), .rst(rst),
        .imem_req(imem_req), .imem_addr(imem_addr),
        .imem_rdata(imem_rdata), .imem_ack(imem_ack),
        .dmem_req(dmem_req), .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata),
        .dmem_strb(dmem_strb), .dmem_ack(dmem_ack)
    );

    bind vector_core vector_core_chk i_chk (
        .clk(clk), .rst(rst),
        .imem_req(imem_req), .imem_addr(imem_addr), .imem_ack(imem_ack),
        .dmem_req(dmem_req), .dmem_addr(dmem_addr), .dmem_strb(dmem_strb),
        .dmem_ack(dmem_ack)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // --------------------
    // instruction encoding
    // --------------------
    function automatic word_t itype(int rd, int rs1, int imm);
        return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'h13};
    endfunction

    function automatic word_t rtype(int f7, int rd, int rs1, int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], 3'b000, rd[4:0], 7'h33};
    endfunction

    function automatic word_t stype(int rs2, int rs1, int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'h23};
    endfunction

    function automatic word_t btype(int f3, int rs1, int rs2, int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], 7'h63};
    endfunction

    // zimm asks for e32, m1
    function automatic word_t vsetvli_word(int rd, int rs1);
        return {1'b0, 11'h010, rs1[4:0], 3'b111, rd[4:0], 7'h57};
    endfunction

    function automatic word_t varith(int f6, int f3, int vm, int vd, int vs2, int rs1);
        return {f6[5:0], vm[0], vs2[4:0], rs1[4:0], f3[2:0], vd[4:0], 7'h57};
    endfunction

    function automatic word_t vse_word(int vm, int vs3, int rs1);
        return {6'b000000, vm[0], 5'b00000, rs1[4:0], 3'b110, vs3[4:0], 7'h27};
    endfunction

    task automatic load_program();
        prog.delete();
        // scalar arithmetic, negative offset store
        prog.push_back(itype(1, 0, 100));
        prog.push_back(itype(2, 0, -7));
        prog.push_back(rtype(7'h00, 3, 1, 2));
        prog.push_back(rtype(7'h20, 4, 1, 2));
        prog.push_back(stype(3, 1, 0));
        prog.push_back(stype(4, 1, -4));
        // beq untaken, bne taken, beq taken, bne untaken
        prog.push_back(btype(0, 1, 2, 8));
        prog.push_back(stype(1, 0, 16));
        prog.push_back(btype(1, 1, 2, 8));
        prog.push_back(stype(2, 0, 20));
        prog.push_back(btype(0, 3, 3, 8));
        prog.push_back(stype(2, 0, 24));
        prog.push_back(btype(1, 4, 4, 8));
        prog.push_back(stype(2, 0, 28));
        // vl from 12 clamps to 8
        prog.push_back(itype(5, 0, 12));
        prog.push_back(vsetvli_word(7, 5));
        prog.push_back(stype(7, 0, 36));
        prog.push_back(itype(8, 0, 3));
        prog.push_back(varith(23, 4, 1, 1, 0, 8));
        prog.push_back(itype(9, 0, 1000));
        prog.push_back(varith(23, 4, 1, 2, 0, 9));
        prog.push_back(varith(0, 4, 1, 3, 1, 9));
        // vl of 5 leaves a tail of three elements
        prog.push_back(itype(5, 0, 5));
        prog.push_back(vsetvli_word(6, 5));
        prog.push_back(stype(6, 0, 32));
        prog.push_back(varith(0, 0, 1, 2, 2, 3));
        prog.push_back(itype(10, 0, 512));
        prog.push_back(vse_word(1, 2, 10));
        // mask pattern 0xa5 in v0, then masked add and stores
        prog.push_back(itype(11, 0, 165));
        prog.push_back(varith(23, 4, 1, 0, 0, 11));
        prog.push_back(varith(0, 0, 0, 1, 1, 3));
        prog.push_back(itype(12, 0, 768));
        prog.push_back(vse_word(1, 1, 12));
        prog.push_back(itype(13, 0, 1024));
        prog.push_back(vse_word(0, 1, 13));
        prog.push_back(btype(0, 0, 0, 0));
    endtask

    // --------------------
    // reference model
    // --------------------
    function automatic void expect_store(int pc, addr_t a, strb_t s, vreg_t d);
        exp_pc.push_back(pc);
        exp_addr.push_back(a);
        exp_strb.push_back(s);
        exp_data.push_back(d);
    endfunction

    // executes the program, returns the number of stores it makes
    function automatic int run_model();
        word_t      x [32];
        word_t      v [32][VLEN_ELEMS];
        word_t      w, a, b, immv;
        vreg_t      data;
        strb_t      strb;
        int         pc, vl, steps;
        logic [2:0] f3;
        logic [4:0] rd, rs1, rs2;
        logic       vm;
        for (int r = 0; r < 32; r++) begin
            x[r] = '0;
            for (int e = 0; e < VLEN_ELEMS; e++) v[r][e] = '0;
        end
        pc = 0;
        vl = 0;
        for (steps = 0; steps < 200; steps++) begin
            w   = prog[pc];
            f3  = w[14:12];
            rd  = w[11:7];
            rs1 = w[19:15];
            rs2 = w[24:20];
            vm  = w[25];
            a   = x[rs1];
            b   = x[rs2];
            case (w[6:0])
                7'h13: x[rd] = a + {{20{w[31]}}, w[31:20]};
                7'h33: x[rd] = w[30] ? a - b : a + b;
                7'h23: begin
                    immv = {{20{w[31]}}, w[31:25], w[11:7]};
                    expect_store(pc, addr_t'(a + immv), strb_t'(32'hF), vreg_t'(b));
                end
                7'h63: begin
                    immv = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
                    // beq when f3 is 0, bne otherwise
                    if ((f3 == 3'b000) == (a == b)) begin
                        if (immv == '0) return exp_addr.size();
                        pc = pc + int'($signed(immv)) / 4 - 1;
                    end
                end
                7'h57: if (f3 == 3'b111) begin
                    vl    = (a > 8) ? 8 : int'(a);
                    x[rd] = word_t'(vl);
                end else begin
                    for (int e = 0; e < vl; e++) begin
                        if (vm || v[0][0][e]) begin
                            if (f3 == 3'b000) v[rd][e] = v[rs2][e] + v[rs1][e];
                            else if (w[31:26] == '0) v[rd][e] = v[rs2][e] + a;
                            else v[rd][e] = a;
                        end
                    end
                end
                7'h27: begin
                    data = '0;
                    strb = '0;
                    for (int e = 0; e < vl; e++) begin
                        if (vm || v[0][0][e]) begin
                            data[32*e +: 32] = v[rd][e];
                            strb[4*e +: 4]   = 4'hF;
                        end
                    end
                    expect_store(pc, addr_t'(a), strb, data);
                end
                default: ;
            endcase
            x[0] = '0;
            pc   = pc + 1;
        end
        return exp_addr.size();
    endfunction

    // --------------------
    // helpers
    // --------------------
    task automatic check_value(input string name, input vreg_t expected, input vreg_t actual);
        n_checks++;
        if (expected !== actual) begin
            n_errors++;
            $display("ERROR %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    function automatic vreg_t strb_mask(strb_t s);
        vreg_t m;
        for (int i = 0; i < STRB_BITS; i++) m[8*i +: 8] = {8{s[i]}};
        return m;
    endfunction

    function automatic int ack_delay();
        return $unsigned($random(seed)) % 4;
    endfunction

    function automatic word_t fetch_word(addr_t a);
        int idx;
        idx = int'(a >> 2);
        if (idx < prog.size()) return prog[idx];
        // unused space decodes as an illegal instruction
        return {a, 12'h000};
    endfunction

    // --------------------
    // memory slaves
    // --------------------
    initial begin : fetch_slave
        int wait_cnt;
        wait_cnt = -1;
        forever begin
            @(posedge clk);
            if (rst && imem_req && !imem_ack) begin
                if (wait_cnt < 0) wait_cnt = ack_delay();
                if (wait_cnt == 0) begin
                    imem_rdata <= fetch_word(imem_addr);
                    imem_ack   <= 1'b1;
                end
                wait_cnt = wait_cnt - 1;
            end else if (!imem_req && imem_ack) begin
                imem_ack <= 1'b0;
            end
        end
    end

    initial begin : store_slave
        int wait_cnt;
        wait_cnt = -1;
        forever begin
            @(posedge clk);
            if (rst && dmem_req && !dmem_ack) begin
                if (wait_cnt < 0) wait_cnt = ack_delay();
                if (wait_cnt == 0) begin
                    got_addr.push_back(dmem_addr);
                    got_strb.push_back(dmem_strb);
                    got_data.push_back(dmem_wdata & strb_mask(dmem_strb));
                    stores_seen++;
                    dmem_ack <= 1'b1;
                end
                wait_cnt = wait_cnt - 1;
            end else if (!dmem_req && dmem_ack) begin
                dmem_ack <= 1'b0;
            end
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        wait (rst === 1'b1);
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles with %0d of %0d stores seen",
                 cycles, stores_seen, exp_addr.size());
        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        $display("TESTBENCH FAILED");
        $finish;
    end

    // --------------------
    // stimulus and compare
    // --------------------
    initial begin : main
        string name;
        int    n;
        int    n_exp;
        addr_t loop_addr;
        int    loop_seen;
        rst         = 1'b0;
        imem_ack    = 1'b0;
        imem_rdata  = '0;
        dmem_ack    = 1'b0;
        seed        = 32'h9348_2ea8;
        n_checks    = 0;
        n_errors    = 0;
        stores_seen = 0;
        load_program();
        n_exp       = run_model();
        cycle_limit = 400 * n_exp;
        repeat (3) @(posedge clk);
        rst <= 1'b1;
        for (n = 0; n < n_exp; n++) begin
            while (got_addr.size() == 0) @(posedge clk);
            name = $sformatf("store %0d at pc %0d", n, 4 * exp_pc[n]);
            check_value({name, " addr"}, vreg_t'(exp_addr[n]), vreg_t'(got_addr.pop_front()));
            check_value({name, " strb"}, vreg_t'(exp_strb[n]), vreg_t'(got_strb.pop_front()));
            check_value({name, " data"}, exp_data[n], got_data.pop_front());
        end
        // final branch fetched twice, so the core spins on it
        loop_addr = addr_t'(4 * (prog.size() - 1));
        loop_seen = 0;
        while (loop_seen < 2) begin
            @(posedge clk);
            if (imem_req && imem_ack && imem_addr == loop_addr) loop_seen++;
        end
        check_value("extra stores", '0, vreg_t'(got_addr.size()));
        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- sim/vector_core_chk.sv
// handshake checker
// concurrent assertions on the fetch and store req/ack ports,
// bound into the vector core top level
`timescale 1ns/1ns

module vector_core_chk import core_pkg::*; (
    input logic  clk,
    input logic  rst,
    input logic  imem_req,
    input addr_t imem_addr,
    input logic  imem_ack,
    input logic  dmem_req,
    input addr_t dmem_addr,
    input strb_t dmem_strb,
    input logic  dmem_ack
);

    // req stays up until the slave answers
    fetch_req_held: assert property (@(posedge clk) disable iff (!rst)
        imem_req && !imem_ack |=> imem_req)
        else $error("fetch req dropped before ack");
    store_req_held: assert property (@(posedge clk) disable iff (!rst)
        dmem_req && !dmem_ack |=> dmem_req)
        else $error("store req dropped before ack");

    // address frozen for the whole transfer
    fetch_addr_stable: assert property (@(posedge clk) disable iff (!rst)
        imem_req |=> !imem_req || $stable(imem_addr))
        else $error("fetch address changed while req high");
    store_addr_stable: assert property (@(posedge clk) disable iff (!rst)
        dmem_req |=> !dmem_req || $stable(dmem_addr))
        else $error("store address changed while req high");

    one_port_busy: assert property (@(posedge clk) disable iff (!rst)
        !(imem_req && dmem_req))
        else $error("fetch and store requests both high");

    strb_idle_zero: assert property (@(posedge clk) disable iff (!rst)
        !dmem_req |-> dmem_strb == '0)
        else $error("store strobes nonzero while req low");

endmodule

//--- src/vector_core.sv
// vector core top level
// multicycle RV32 core with a two-lane vector unit; instructions come
// in over one four-phase port, stores leave over a second one
`timescale 1ns/1ns

module vector_core import core_pkg::*; import isa_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    output logic  imem_req,
    output addr_t imem_addr,
    input  word_t imem_rdata,
    input  logic  imem_ack,
    output logic  dmem_req,
    output addr_t dmem_addr,
    output vreg_t dmem_wdata,
    output strb_t dmem_strb,
    input  logic  dmem_ack
);

    op_t      dec_op;
    reg_idx_t dec_rs1, dec_rs2, dec_rd;
    logic     dec_vm;
    word_t    dec_imm;
    word_t    ir, fetch_data;
    addr_t    pc, st_addr;
    word_t    rs1_data, rs2_data, x_wdata;
    vreg_t    vs1_data, vs2_data, vs3_data, v0_data;
    vreg_t    vresult, v_wdata, st_data;
    strb_t    st_strb;
    vl_t      vl;
    logic     if_start, if_done, st_start, st_done;
    logic     vstart, vdone, x_we, v_we;

    decoder i_decoder (
        .instr(ir), .op(dec_op), .rs1(dec_rs1), .rs2(dec_rs2), .rd(dec_rd),
        .vm(dec_vm), .imm(dec_imm)
    );

    scalar_reg_file i_scalar_rf (
        .clk(clk), .rst(rst), .rs1(dec_rs1), .rs2(dec_rs2),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .we(x_we), .rd(dec_rd), .wdata(x_wdata)
    );

    // vs3 is the rd field: old vd or vse32 source
    vector_reg_file i_vector_rf (
        .clk(clk), .rst(rst), .vs1(dec_rs1), .vs2(dec_rs2), .vs3(dec_rd),
        .vs1_data(vs1_data), .vs2_data(vs2_data), .vs3_data(vs3_data),
        .v0_data(v0_data), .we(v_we), .vd(dec_rd), .wdata(v_wdata)
    );

    vector_alu i_vector_alu (
        .clk(clk), .rst(rst), .vstart(vstart), .op(dec_op), .vl(vl), .vm(dec_vm),
        .mask(v0_data), .va(vs2_data), .vb(vs1_data), .scalar(rs1_data),
        .vd_old(vs3_data), .result(vresult), .vdone(vdone)
    );

    mem_port #(.DATA_W(XLEN)) i_fetch_port (
        .clk(clk), .rst(rst), .start(if_start), .addr_in(pc), .wdata_in('0),
        .strb_in('0), .done(if_done), .rdata(fetch_data), .req(imem_req),
        .addr(imem_addr), .wdata(), .strb(), .ack(imem_ack), .rack(imem_rdata)
    );

    mem_port #(.DATA_W(VREG_BITS)) i_store_port (
        .clk(clk), .rst(rst), .start(st_start), .addr_in(st_addr), .wdata_in(st_data),
        .strb_in(st_strb), .done(st_done), .rdata(), .req(dmem_req),
        .addr(dmem_addr), .wdata(dmem_wdata), .strb(dmem_strb), .ack(dmem_ack),
        .rack('0)
    );

    core_control i_control (
        .clk(clk), .rst(rst), .op(dec_op), .rs1_idx(dec_rs1), .rd(dec_rd),
        .vm(dec_vm), .imm(dec_imm), .instr(fetch_data),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .vs3_data(vs3_data), .v0_data(v0_data), .vresult(vresult),
        .vdone(vdone), .if_done(if_done), .st_done(st_done),
        .pc(pc), .ir(ir), .if_start(if_start), .st_start(st_start),
        .vstart(vstart), .vl(vl), .st_addr(st_addr), .st_data(st_data),
        .st_strb(st_strb), .x_we(x_we), .x_wdata(x_wdata),
        .v_we(v_we), .v_wdata(v_wdata)
    );

endmodule

//--- src/core_control.sv
// core control
// stage sequencer with PC and vl; runs scalar execute, branch decision
// and store formatting, and hands out start pulses and write enables
`timescale 1ns/1ns

module core_control import core_pkg::*; import isa_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  op_t      op,
    input  reg_idx_t rs1_idx,
    input  reg_idx_t rd,
    input  logic     vm,
    input  word_t    imm,
    input  word_t    instr,
    input  word_t    rs1_data,
    input  word_t    rs2_data,
    input  vreg_t    vs3_data,
    input  vreg_t    v0_data,
    input  vreg_t    vresult,
    input  logic     vdone,
    input  logic     if_done,
    input  logic     st_done,
    output addr_t    pc,
    output word_t    ir,
    output logic     if_start,
    output logic     st_start,
    output logic     vstart,
    output vl_t      vl,
    output addr_t    st_addr,
    output vreg_t    st_data,
    output strb_t    st_strb,
    output logic     x_we,
    output word_t    x_wdata,
    output logic     v_we,
    output vreg_t    v_wdata
);

    stage_t stage;
    logic   issued;
    logic   take_br;
    word_t  op_a;
    word_t  op_b;
    word_t  imm_q;
    vl_t    new_vl;
    strb_t  vse_strb;
    logic   is_varith;
    logic   is_store;

    assign is_varith = op inside {OP_VADD_VV, OP_VADD_VX, OP_VMV_VX};
    assign is_store  = op inside {OP_SW, OP_VSE};

    // one start per visit of a waiting stage
    assign if_start = (stage == S_FETCH) && !issued;
    assign st_start = (stage == S_STORE) && !issued;
    assign vstart   = (stage == S_VWAIT) && !issued;

    assign x_we    = (stage == S_WB) && (op inside {OP_ADDI, OP_ADD, OP_SUB, OP_VSETVL});
    assign v_we    = (stage == S_WB) && is_varith;
    assign v_wdata = vresult;

    // vsetvli: rs1 = x0 asks for VLMAX, or keeps vl when rd is x0 too
    always_comb begin
        if (rs1_idx != '0) begin
            new_vl = (op_a > word_t'(VLEN_ELEMS)) ? vl_t'(VLEN_ELEMS) : vl_t'(op_a);
        end else if (rd != '0) begin
            new_vl = vl_t'(VLEN_ELEMS);
        end else begin
            new_vl = vl;
        end
    end

    // vse32 strobes, four bytes per active body element
    always_comb begin
        vse_strb = '0;
        for (int i = 0; i < VLEN_ELEMS; i++) begin
            if (i < int'(vl) && (vm || v0_data[i])) vse_strb[4*i +: 4] = 4'hF;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            stage   <= S_FETCH;
            pc      <= '0;
            vl      <= '0;
            issued  <= 1'b0;
            take_br <= 1'b0;
        end else begin
            issued <= issued || if_start || st_start || vstart;
            case (stage)
                S_FETCH: if (if_done) begin
                    ir     <= instr;
                    issued <= 1'b0;
                    stage  <= S_DECODE;
                end
                S_DECODE: begin
                    op_a  <= rs1_data;
                    op_b  <= rs2_data;
                    imm_q <= imm;
                    stage <= S_EXEC;
                end
                S_EXEC: begin
                    take_br <= (op == OP_BEQ && op_a == op_b) ||
                               (op == OP_BNE && op_a != op_b);
                    case (op)
                        OP_ADDI:   x_wdata <= op_a + imm_q;
                        OP_ADD:    x_wdata <= op_a + op_b;
                        OP_SUB:    x_wdata <= op_a - op_b;
                        OP_VSETVL: begin
                            vl      <= new_vl;
                            x_wdata <= word_t'(new_vl);
                        end
                        default: ;
                    endcase
                    if (is_varith) stage <= S_VWAIT;
                    else if (is_store) stage <= S_STORE;
                    else stage <= S_WB;
                end
                S_VWAIT: if (vdone) begin
                    issued <= 1'b0;
                    stage  <= S_WB;
                end
                S_STORE: if (st_done) begin
                    issued <= 1'b0;
                    stage  <= S_WB;
                end
                S_WB: begin
                    pc    <= take_br ? pc + addr_t'(imm_q) : pc + addr_t'(4);
                    stage <= S_FETCH;
                end
                default: stage <= S_FETCH;
            endcase
        end
    end

    // --------------------
    // store formatting
    // --------------------
    always_ff @(posedge clk) begin
        if (stage == S_EXEC) begin
            if (op == OP_VSE) begin
                st_addr <= addr_t'(op_a);
                st_data <= vs3_data;
                st_strb <= vse_strb;
            end else begin
                // sw: word in element 0
                st_addr <= addr_t'(op_a + imm_q);
                st_data <= vreg_t'(op_b);
                st_strb <= strb_t'(32'h0000_000F);
            end
        end
    end

endmodule

//--- src/mem_port.sv
// memory port master
// runs one four-phase req/ack transfer per start pulse; address, data
// and strobes hold while req is high, read data is taken with ack
`timescale 1ns/1ns

module mem_port import core_pkg::*; #(
    parameter int DATA_W = 32
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    input  addr_t             addr_in,
    input  logic [DATA_W-1:0] wdata_in,
    input  strb_t             strb_in,
    output logic              done,
    output word_t             rdata,
    output logic              req,
    output addr_t             addr,
    output logic [DATA_W-1:0] wdata,
    output strb_t             strb,
    input  logic              ack,
    input  word_t             rack
);

    typedef enum logic [1:0] {
        MP_IDLE,
        MP_WAIT_HI,
        MP_WAIT_LO
    } mp_state_t;

    mp_state_t state;

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= MP_IDLE;
            req   <= 1'b0;
            strb  <= '0;
        end else begin
            case (state)
                MP_IDLE: if (start) begin
                    req   <= 1'b1;
                    strb  <= strb_in;
                    state <= MP_WAIT_HI;
                end
                MP_WAIT_HI: if (ack) begin
                    // strobes drop together with req
                    req   <= 1'b0;
                    strb  <= '0;
                    state <= MP_WAIT_LO;
                end
                MP_WAIT_LO: if (!ack) state <= MP_IDLE;
                default: state <= MP_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == MP_IDLE && start) begin
            addr  <= addr_in;
            wdata <= wdata_in;
        end
        if (state == MP_WAIT_HI && ack) rdata <= rack;
    end

    // slave has released ack, transfer complete
    assign done = (state == MP_WAIT_LO) && !ack;

endmodule

//--- src/vector_alu.sv
// vector ALU
// masked, vl-limited element add and broadcast, two elements per cycle;
// inactive or tail elements keep the old destination value
`timescale 1ns/1ns

module vector_alu import core_pkg::*; import isa_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  vstart,
    input  op_t   op,
    input  vl_t   vl,
    input  logic  vm,
    input  vreg_t mask,
    input  vreg_t va,
    input  vreg_t vb,
    input  word_t scalar,
    input  vreg_t vd_old,
    output vreg_t result,
    output logic  vdone
);

    logic  busy;
    vl_t   idx;
    vl_t   lane_base;
    vl_t   e;
    word_t lane_val;
    logic  last;
    vreg_t next_result;

    // --------------------
    // lane datapath
    // --------------------
    always_comb begin
        lane_base   = vstart ? '0 : idx;
        next_result = vstart ? vd_old : result;
        e           = '0;
        lane_val    = '0;
        for (int l = 0; l < LANES; l++) begin
            e = lane_base + vl_t'(l);
            case (op)
                OP_VADD_VV: lane_val = va[e*XLEN +: XLEN] + vb[e*XLEN +: XLEN];
                OP_VADD_VX: lane_val = va[e*XLEN +: XLEN] + scalar;
                default:    lane_val = scalar;
            endcase
            if (e < vl && (vm || mask[e])) begin
                next_result[e*XLEN +: XLEN] = lane_val;
            end
        end
    end

    // this pair reaches the end of vl
    assign last = (int'(lane_base) + LANES) >= int'(vl);

    // --------------------
    // element sequencing
    // --------------------
    always_ff @(posedge clk) begin
        if (!rst) begin
            busy  <= 1'b0;
            vdone <= 1'b0;
            idx   <= '0;
        end else begin
            vdone <= 1'b0;
            if (vstart || busy) begin
                idx   <= lane_base + vl_t'(LANES);
                busy  <= !last;
                vdone <= last;
            end
        end
    end

    // result stays put until the next vstart
    always_ff @(posedge clk) begin
        if (vstart || busy) begin
            result <= next_result;
        end
    end

endmodule

//--- src/vector_reg_file.sv
// vector register file
// 32 x 256-bit registers with three read ports and a fixed v0 read
// for masking, whole-register write
`timescale 1ns/1ns

module vector_reg_file import core_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  reg_idx_t vs1,
    input  reg_idx_t vs2,
    input  reg_idx_t vs3,
    output vreg_t    vs1_data,
    output vreg_t    vs2_data,
    output vreg_t    vs3_data,
    output vreg_t    v0_data,
    input  logic     we,
    input  reg_idx_t vd,
    input  vreg_t    wdata
);

    vreg_t regs [32];

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[vd] <= wdata;
        end
    end

    assign vs1_data = regs[vs1];
    assign vs2_data = regs[vs2];
    // old destination, or the source of a vector store
    assign vs3_data = regs[vs3];
    assign v0_data  = regs[0];

endmodule

//--- src/scalar_reg_file.sv
// scalar register file
// 32 x 32-bit, two asynchronous read ports, one write port, x0 reads zero
`timescale 1ns/1ns

module scalar_reg_file import core_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    output word_t    rs1_data,
    output word_t    rs2_data,
    input  logic     we,
    input  reg_idx_t rd,
    input  word_t    wdata
);

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

//--- src/decoder.sv
// instruction decoder
// turns a 32-bit instruction into an operation, register indices,
// the mask bit and a sign-extended immediate
`timescale 1ns/1ns

module decoder import core_pkg::*; import isa_pkg::*; (
    input  word_t    instr,
    output op_t      op,
    output reg_idx_t rs1,
    output reg_idx_t rs2,
    output reg_idx_t rd,
    output logic     vm,
    output word_t    imm
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [5:0] funct6;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign funct6 = instr[31:26];

    // fields sit at fixed positions for every format used here
    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];
    assign rd  = instr[11:7];
    assign vm  = instr[25];

    always_comb begin
        op  = OP_ILLEGAL;
        imm = '0;
        case (opcode)
            OP_IMM: begin
                imm = {{20{instr[31]}}, instr[31:20]};
                if (funct3 == F3_ADD) op = OP_ADDI;
            end
            OP_REG: begin
                if (funct3 == F3_ADD && funct7 == F7_ADD) op = OP_ADD;
                if (funct3 == F3_ADD && funct7 == F7_SUB) op = OP_SUB;
            end
            OP_STORE: begin
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
                if (funct3 == F3_SW) op = OP_SW;
            end
            OP_BRANCH: begin
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                       instr[11:8], 1'b0};
                if (funct3 == F3_BEQ) op = OP_BEQ;
                if (funct3 == F3_BNE) op = OP_BNE;
            end
            OP_V: begin
                // vsetvli only, zimm is not looked at
                if (funct3 == F3_OPCFG && !instr[31]) op = OP_VSETVL;
                if (funct3 == F3_OPIVV && funct6 == F6_VADD) op = OP_VADD_VV;
                if (funct3 == F3_OPIVX && funct6 == F6_VADD) op = OP_VADD_VX;
                if (funct3 == F3_OPIVX && funct6 == F6_VMV && vm && rs2 == '0) begin
                    op = OP_VMV_VX;
                end
            end
            OP_VSTORE: begin
                // unit stride, nf = 0, 32-bit elements
                if (funct3 == F3_VSE32 && funct6 == '0 && rs2 == '0) op = OP_VSE;
            end
            default: op = OP_ILLEGAL;
        endcase
    end

endmodule

//--- src/isa_pkg.sv
// isa package
// opcode and funct encodings of the supported RISC-V subset and
// the operation code handed out by the decoder
package isa_pkg;

    // major opcodes
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_V      = 7'b1010111;
    localparam logic [6:0] OP_VSTORE = 7'b0100111;

    // scalar funct3 / funct7
    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_SW  = 3'b010;
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;
    localparam logic [6:0] F7_ADD = 7'b0000000;
    localparam logic [6:0] F7_SUB = 7'b0100000;

    // vector funct3 categories and funct6
    localparam logic [2:0] F3_OPIVV = 3'b000;
    localparam logic [2:0] F3_OPIVX = 3'b100;
    localparam logic [2:0] F3_OPCFG = 3'b111;
    localparam logic [2:0] F3_VSE32 = 3'b110;
    localparam logic [5:0] F6_VADD  = 6'b000000;
    localparam logic [5:0] F6_VMV   = 6'b010111;

    typedef enum logic [3:0] {
        OP_ADDI,
        OP_ADD,
        OP_SUB,
        OP_SW,
        OP_BEQ,
        OP_BNE,
        OP_VSETVL,
        OP_VADD_VV,
        OP_VADD_VX,
        OP_VMV_VX,
        OP_VSE,
        OP_ILLEGAL
    } op_t;

endpackage

//--- src/core_pkg.sv
// core package
// widths, data typedefs and the stage encoding shared by the
// vector core and its units
package core_pkg;

    localparam int XLEN       = 32;
    localparam int VLEN_ELEMS = 8;
    localparam int VREG_BITS  = XLEN * VLEN_ELEMS;
    localparam int STRB_BITS  = 32;
    localparam int LANES      = 2;
    localparam int ADDR_W     = 20;

    typedef logic [XLEN-1:0]      word_t;
    typedef logic [VREG_BITS-1:0] vreg_t;
    typedef logic [4:0]           reg_idx_t;
    typedef logic [ADDR_W-1:0]    addr_t;
    typedef logic [STRB_BITS-1:0] strb_t;
    // 0 to 8 elements
    typedef logic [3:0]           vl_t;

    // one instruction in flight, one stage at a time
    typedef enum logic [2:0] {
        S_FETCH,
        S_DECODE,
        S_EXEC,
        S_VWAIT,
        S_STORE,
        S_WB
    } stage_t;

endpackage
